//--- rtl/imu_pkg.sv
package imu_pkg;

    // sensor bus address, AD0 tied low
    localparam logic [6:0] I2C_DEV_ADDR = 7'h68;

    // power management, a zero clears the sleep bit
    localparam logic [7:0] REG_PWR_MGMT   = 8'h6B;
    localparam logic [7:0] PWR_WAKE_VALUE = 8'h00;

    // first register of the accel/temp/gyro block
    localparam logic [7:0] REG_ACCEL_XOUT_H = 8'h3B;

    // accel xyz, temp, gyro xyz at two bytes each
    localparam int unsigned BURST_LEN = 14;

    typedef logic [7:0]  byte_t;    // one byte on the bus
    typedef logic [3:0]  len_t;     // byte count of a command
    typedef logic [31:0] word_t;    // packed output word

endpackage

//--- rtl/i2c_scl_gen.sv
module i2c_scl_gen #(
    parameter int SCL_LOW_CYCLES  = 125,
    parameter int SCL_HIGH_CYCLES = 125
) (
    input  logic clk_i,
    input  logic reset_n,
    input  logic run_i,
    output logic scl_low_o,
    output logic mid_low_o,
    output logic mid_high_o
);

    localparam int MAX_CYCLES = (SCL_LOW_CYCLES > SCL_HIGH_CYCLES) ?
                                SCL_LOW_CYCLES : SCL_HIGH_CYCLES;
    localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             scl_low_q;    // 1 while scl is pulled low

    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q     <= '0;
            scl_low_q <= 1'b0;
        end else if (!run_i) begin
            cnt_q     <= '0;        // next run opens with a high phase
            scl_low_q <= 1'b0;
        end else if (scl_low_q && cnt_q == CNT_W'(SCL_LOW_CYCLES - 1)) begin
            cnt_q     <= '0;
            scl_low_q <= 1'b0;
        end else if (!scl_low_q && cnt_q == CNT_W'(SCL_HIGH_CYCLES - 1)) begin
            cnt_q     <= '0;
            scl_low_q <= 1'b1;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign scl_low_o  = scl_low_q;
    assign mid_low_o  = run_i && scl_low_q && cnt_q == CNT_W'(SCL_LOW_CYCLES / 2);
    assign mid_high_o = run_i && !scl_low_q && cnt_q == CNT_W'(SCL_HIGH_CYCLES / 2);

endmodule

//--- rtl/i2c_byte_engine.sv
module i2c_byte_engine #(
    parameter int SCL_LOW_CYCLES  = 125,
    parameter int SCL_HIGH_CYCLES = 125
) (
    input  logic           clk_i,
    input  logic           reset_n,
    input  logic           sda_i,
    input  logic           cmd_start_i,
    input  logic           cmd_read_i,
    input  imu_pkg::byte_t cmd_reg_addr_i,
    input  imu_pkg::byte_t cmd_wdata_i,
    input  imu_pkg::len_t  cmd_len_i,
    output logic           scl_oe_o,
    output logic           sda_oe_o,
    output logic           busy_o,
    output logic           rx_valid_o,
    output logic           done_o,
    output logic           nack_o,
    output imu_pkg::byte_t rx_byte_o
);

    typedef enum logic [2:0] {
        IDLE, START, TX_BIT, TX_ACK, RSTART, RX_BIT, RX_ACK, STOP
    } state_t;

    // which byte the current TX_BIT run carries
    typedef enum logic [1:0] {
        TX_DEV_W, TX_REG, TX_DATA, TX_DEV_R
    } tx_stage_t;

    state_t         state_q;
    tx_stage_t      stage_q;
    logic           run_q;
    logic           read_q;
    imu_pkg::byte_t reg_addr_q;
    imu_pkg::byte_t wdata_q;
    imu_pkg::len_t  len_q;
    imu_pkg::len_t  byte_cnt_q;
    imu_pkg::byte_t shift_q;
    logic [2:0]     bit_cnt_q;
    logic           mid_low;
    logic           mid_high;
    logic           last_byte;

    i2c_scl_gen #(
        .SCL_LOW_CYCLES  (SCL_LOW_CYCLES),
        .SCL_HIGH_CYCLES (SCL_HIGH_CYCLES)
    ) i_scl_gen (
        .clk_i      (clk_i),
        .reset_n    (reset_n),
        .run_i      (run_q),
        .scl_low_o  (scl_oe_o),
        .mid_low_o  (mid_low),
        .mid_high_o (mid_high)
    );

    assign last_byte = (byte_cnt_q == len_q - 1'b1);

    // every state changes sda at mid_low and decides at mid_high
    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= IDLE;
            stage_q    <= TX_DEV_W;
            run_q      <= 1'b0;
            read_q     <= 1'b0;
            reg_addr_q <= '0;
            wdata_q    <= '0;
            len_q      <= '0;
            byte_cnt_q <= '0;
            shift_q    <= '0;
            bit_cnt_q  <= '0;
            sda_oe_o   <= 1'b0;
            busy_o     <= 1'b0;
            rx_valid_o <= 1'b0;
            done_o     <= 1'b0;
            nack_o     <= 1'b0;
            rx_byte_o  <= '0;
        end else begin
            rx_valid_o <= 1'b0;
            done_o     <= 1'b0;
            nack_o     <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cmd_start_i) begin
                        read_q     <= cmd_read_i;
                        reg_addr_q <= cmd_reg_addr_i;
                        wdata_q    <= cmd_wdata_i;
                        len_q      <= cmd_len_i;
                        shift_q    <= {imu_pkg::I2C_DEV_ADDR, 1'b0};   // address + write
                        stage_q    <= TX_DEV_W;
                        bit_cnt_q  <= '0;
                        byte_cnt_q <= '0;
                        busy_o     <= 1'b1;
                        run_q      <= 1'b1;
                        state_q    <= START;
                    end
                end
                START: begin
                    if (mid_high) begin
                        sda_oe_o <= 1'b1;           // sda falls while scl high
                        state_q  <= TX_BIT;
                    end
                end
                TX_BIT: begin
                    if (mid_low) begin
                        sda_oe_o <= ~shift_q[7];    // msb first, pull for a zero
                        shift_q  <= {shift_q[6:0], 1'b0};
                    end
                    if (mid_high) begin
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= TX_ACK;
                        end
                    end
                end
                TX_ACK: begin
                    if (mid_low) begin
                        sda_oe_o <= 1'b0;           // let the sensor drive ack
                    end
                    if (mid_high) begin
                        if (sda_i) begin
                            nack_o  <= 1'b1;        // no ack, give up the bus
                            busy_o  <= 1'b0;
                            run_q   <= 1'b0;
                            state_q <= IDLE;
                        end else begin
                            case (stage_q)
                                TX_DEV_W: begin
                                    shift_q <= reg_addr_q;
                                    stage_q <= TX_REG;
                                    state_q <= TX_BIT;
                                end
                                TX_REG: begin
                                    if (read_q) begin
                                        state_q <= RSTART;
                                    end else begin
                                        shift_q <= wdata_q;
                                        stage_q <= TX_DATA;
                                        state_q <= TX_BIT;
                                    end
                                end
                                TX_DATA: state_q <= STOP;
                                default: state_q <= RX_BIT;     // read address acked
                            endcase
                        end
                    end
                end
                RSTART: begin
                    if (mid_low) begin
                        sda_oe_o <= 1'b0;           // sda high before repeated start
                    end
                    if (mid_high) begin
                        sda_oe_o <= 1'b1;
                        shift_q  <= {imu_pkg::I2C_DEV_ADDR, 1'b1};   // address + read
                        stage_q  <= TX_DEV_R;
                        state_q  <= TX_BIT;
                    end
                end
                RX_BIT: begin
                    if (mid_low) begin
                        sda_oe_o <= 1'b0;
                    end
                    if (mid_high) begin
                        shift_q   <= {shift_q[6:0], sda_i};
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7) begin
                            rx_byte_o  <= {shift_q[6:0], sda_i};
                            rx_valid_o <= 1'b1;
                            state_q    <= RX_ACK;
                        end
                    end
                end
                RX_ACK: begin
                    if (mid_low) begin
                        sda_oe_o <= ~last_byte;     // nack the final byte
                    end
                    if (mid_high) begin
                        if (last_byte) begin
                            state_q <= STOP;
                        end else begin
                            byte_cnt_q <= byte_cnt_q + 1'b1;
                            state_q    <= RX_BIT;
                        end
                    end
                end
                STOP: begin
                    if (mid_low) begin
                        sda_oe_o <= 1'b1;
                    end
                    if (mid_high) begin
                        sda_oe_o <= 1'b0;           // sda rises while scl high
                        run_q    <= 1'b0;
                        busy_o   <= 1'b0;
                        done_o   <= 1'b1;
                        state_q  <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // sequencer only starts a command once the previous one has ended
    a_start_when_idle: assert property (
        @(posedge clk_i) disable iff (!reset_n) cmd_start_i |-> !busy_o);

    a_rx_only_on_read: assert property (
        @(posedge clk_i) disable iff (!reset_n) rx_valid_o |-> read_q);

endmodule

//--- rtl/imu_sequencer.sv
module imu_sequencer #(
    parameter int POLL_CYCLES = 1_000_000
) (
    input  logic           clk_i,
    input  logic           reset_n,
    input  logic           eng_done_i,
    input  logic           eng_nack_i,
    output logic           cmd_start_o,
    output logic           cmd_read_o,
    output logic           burst_begin_o,
    output logic           error_o,
    output imu_pkg::byte_t cmd_reg_addr_o,
    output imu_pkg::byte_t cmd_wdata_o,
    output imu_pkg::len_t  cmd_len_o
);

    typedef enum logic [2:0] {
        WAKE, WAIT_WAKE, POLL_WAIT, BURST, WAIT_BURST, FAULT
    } state_t;

    localparam int POLL_W = $clog2(POLL_CYCLES + 1);

    state_t            state_q;
    logic [POLL_W-1:0] poll_cnt_q;

    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            state_q        <= WAKE;
            poll_cnt_q     <= '0;
            cmd_start_o    <= 1'b0;
            cmd_read_o     <= 1'b0;
            burst_begin_o  <= 1'b0;
            error_o        <= 1'b0;
            cmd_reg_addr_o <= '0;
            cmd_wdata_o    <= '0;
            cmd_len_o      <= '0;
        end else begin
            cmd_start_o   <= 1'b0;
            burst_begin_o <= 1'b0;
            case (state_q)
                WAKE: begin
                    cmd_start_o    <= 1'b1;     // single write clears sleep
                    cmd_read_o     <= 1'b0;
                    cmd_reg_addr_o <= imu_pkg::REG_PWR_MGMT;
                    cmd_wdata_o    <= imu_pkg::PWR_WAKE_VALUE;
                    cmd_len_o      <= imu_pkg::len_t'(1);
                    state_q        <= WAIT_WAKE;
                end
                WAIT_WAKE, WAIT_BURST: begin
                    if (eng_nack_i) begin
                        error_o <= 1'b1;        // sticky until reset
                        state_q <= FAULT;
                    end else if (eng_done_i) begin
                        poll_cnt_q <= '0;
                        state_q    <= POLL_WAIT;
                    end
                end
                POLL_WAIT: begin
                    if (poll_cnt_q == POLL_W'(POLL_CYCLES - 1)) begin
                        state_q <= BURST;
                    end else begin
                        poll_cnt_q <= poll_cnt_q + 1'b1;
                    end
                end
                BURST: begin
                    cmd_start_o    <= 1'b1;
                    burst_begin_o  <= 1'b1;     // assembler restarts its index
                    cmd_read_o     <= 1'b1;
                    cmd_reg_addr_o <= imu_pkg::REG_ACCEL_XOUT_H;
                    cmd_len_o      <= imu_pkg::len_t'(imu_pkg::BURST_LEN);
                    state_q        <= WAIT_BURST;
                end
                FAULT: state_q <= FAULT;
                default: state_q <= WAKE;
            endcase
        end
    end

    a_no_start_in_fault: assert property (
        @(posedge clk_i) disable iff (!reset_n) !(cmd_start_o && state_q == FAULT));

endmodule

//--- rtl/imu_sample_assembler.sv
module imu_sample_assembler (
    input  logic           clk_i,
    input  logic           reset_n,
    input  logic           burst_begin_i,
    input  logic           rx_valid_i,
    input  imu_pkg::byte_t rx_byte_i,
    output logic           sample_valid_o,
    output imu_pkg::word_t data1_o,
    output imu_pkg::word_t data2_o,
    output imu_pkg::word_t data3_o
);

    localparam imu_pkg::len_t LAST_IDX = imu_pkg::len_t'(imu_pkg::BURST_LEN - 1);

    imu_pkg::len_t  idx_q;
    // bytes 0..12, the last one goes straight into the words
    imu_pkg::byte_t stage_q [imu_pkg::BURST_LEN-1];

    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            idx_q          <= '0;
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= rx_valid_i && idx_q == LAST_IDX;
            if (burst_begin_i) begin
                idx_q <= '0;
            end else if (rx_valid_i) begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_valid_i && idx_q < LAST_IDX) begin
            stage_q[idx_q] <= rx_byte_i;
        end
        if (rx_valid_i && idx_q == LAST_IDX) begin
            data1_o <= {stage_q[2], stage_q[3], stage_q[0], stage_q[1]};     // ay, ax
            data2_o <= {stage_q[8], stage_q[9], stage_q[4], stage_q[5]};     // gx, az
            data3_o <= {stage_q[12], rx_byte_i, stage_q[10], stage_q[11]};   // gz, gy
        end
    end

    // engine never hands over more bytes than one burst holds
    a_idx_in_range: assert property (
        @(posedge clk_i) disable iff (!reset_n)
        idx_q <= imu_pkg::len_t'(imu_pkg::BURST_LEN));

endmodule

//--- rtl/imu_reader_top.sv
module imu_reader_top #(
    parameter int SCL_LOW_CYCLES  = 125,
    parameter int SCL_HIGH_CYCLES = 125,
    parameter int POLL_CYCLES     = 1_000_000
) (
    input  logic           clk_i,
    input  logic           reset_n,
    input  logic           sda_i,
    output logic           scl_oe_o,
    output logic           sda_oe_o,
    output logic           sample_valid_o,
    output logic           error_o,
    output imu_pkg::word_t data1_o,
    output imu_pkg::word_t data2_o,
    output imu_pkg::word_t data3_o
);

    logic           cmd_start;
    logic           cmd_read;
    logic           burst_begin;
    logic           eng_busy;
    logic           rx_valid;
    logic           eng_done;
    logic           eng_nack;
    imu_pkg::byte_t cmd_reg_addr;
    imu_pkg::byte_t cmd_wdata;
    imu_pkg::byte_t rx_byte;
    imu_pkg::len_t  cmd_len;

    imu_sequencer #(
        .POLL_CYCLES (POLL_CYCLES)
    ) i_sequencer (
        .clk_i          (clk_i),
        .reset_n        (reset_n),
        .eng_done_i     (eng_done),
        .eng_nack_i     (eng_nack),
        .cmd_start_o    (cmd_start),
        .cmd_read_o     (cmd_read),
        .burst_begin_o  (burst_begin),
        .error_o        (error_o),
        .cmd_reg_addr_o (cmd_reg_addr),
        .cmd_wdata_o    (cmd_wdata),
        .cmd_len_o      (cmd_len)
    );

    i2c_byte_engine #(
        .SCL_LOW_CYCLES  (SCL_LOW_CYCLES),
        .SCL_HIGH_CYCLES (SCL_HIGH_CYCLES)
    ) i_engine (
        .clk_i          (clk_i),
        .reset_n        (reset_n),
        .sda_i          (sda_i),
        .cmd_start_i    (cmd_start),
        .cmd_read_i     (cmd_read),
        .cmd_reg_addr_i (cmd_reg_addr),
        .cmd_wdata_i    (cmd_wdata),
        .cmd_len_i      (cmd_len),
        .scl_oe_o       (scl_oe_o),
        .sda_oe_o       (sda_oe_o),
        .busy_o         (eng_busy),
        .rx_valid_o     (rx_valid),
        .done_o         (eng_done),
        .nack_o         (eng_nack),
        .rx_byte_o      (rx_byte)
    );

    imu_sample_assembler i_assembler (
        .clk_i          (clk_i),
        .reset_n        (reset_n),
        .burst_begin_i  (burst_begin),
        .rx_valid_i     (rx_valid),
        .rx_byte_i      (rx_byte),
        .sample_valid_o (sample_valid_o),
        .data1_o        (data1_o),
        .data2_o        (data2_o),
        .data3_o        (data3_o)
    );

    // after a fault the bus stays quiet
    a_engine_idle_in_fault: assert property (
        @(posedge clk_i) disable iff (!reset_n) error_o |-> !eng_busy);

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;      // 4 ns period
        end
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (5) @(negedge clk_o);
        reset_n_o = 1'b1;           // released on a falling edge
    end

endmodule

//--- test/i2c_sensor_model.sv
module i2c_sensor_model (
    input  logic       clk_i,
    input  logic       reset_n,
    input  logic       scl_i,
    input  logic       sda_i,
    input  logic       nack_en_i,
    output logic       sda_pull_o,
    output logic       sleep_o,
    output logic       read_before_wake_o,
    output logic [7:0] first_wr_reg_o,
    output logic [7:0] first_wr_data_o,
    output int         write_cnt_o
);

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum {M_IDLE, M_ADDR, M_REG, M_WDATA, M_READ} phase_t;

    logic [7:0] regs [128];     // loaded by the testbench
    phase_t     phase;
    logic       prev_scl;
    logic       prev_sda;
    logic [3:0] bit_cnt;
    logic       in_ack;
    logic       rw;
    logic       mack;           // master acked the last read byte
    logic [7:0] shift;
    logic [7:0] tx;
    logic [7:0] ptr;

    // bus lines are sampled between the DUT's rising edges
    always @(negedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            phase              = M_IDLE;
            prev_scl           = 1'b1;
            prev_sda           = 1'b1;
            bit_cnt            = '0;
            in_ack             = 1'b0;
            rw                 = 1'b0;
            mack               = 1'b0;
            shift              = '0;
            tx                 = '0;
            ptr                = '0;
            sda_pull_o         = 1'b0;
            sleep_o            = 1'b1;    // sensor powers up asleep
            read_before_wake_o = 1'b0;
            first_wr_reg_o     = '0;
            first_wr_data_o    = '0;
            write_cnt_o        = 0;
        end else begin
            if (scl_i && prev_scl && prev_sda && !sda_i) begin
                phase      = M_ADDR;      // start or repeated start
                bit_cnt    = '0;
                in_ack     = 1'b0;
                sda_pull_o = 1'b0;
            end else if (scl_i && prev_scl && !prev_sda && sda_i) begin
                phase      = M_IDLE;      // stop
                in_ack     = 1'b0;
                sda_pull_o = 1'b0;
            end else if (scl_i && !prev_scl) begin
                if (in_ack) begin
                    mack = !sda_i;
                end else begin
                    shift   = {shift[6:0], sda_i};
                    bit_cnt = bit_cnt + 4'd1;
                end
            end else if (!scl_i && prev_scl) begin
                if (in_ack) begin
                    in_ack     = 1'b0;
                    sda_pull_o = 1'b0;
                    bit_cnt    = '0;
                    case (phase)
                        M_ADDR:  phase = rw ? M_READ : M_REG;
                        M_REG:   phase = M_WDATA;
                        M_READ: begin
                            if (!mack) begin
                                phase = M_IDLE;
                            end
                        end
                        default: ;
                    endcase
                    if (phase == M_READ) begin
                        tx         = regs[ptr[6:0]];
                        sda_pull_o = !tx[7];
                    end
                end else if (bit_cnt == 4'd8) begin
                    in_ack = 1'b1;
                    case (phase)
                        M_ADDR: begin
                            if (shift[7:1] == 7'h68 && !nack_en_i) begin
                                rw         = shift[0];
                                sda_pull_o = 1'b1;
                            end else begin
                                phase = M_IDLE;   // refuse the address
                            end
                        end
                        M_REG: begin
                            ptr        = shift;
                            sda_pull_o = 1'b1;
                        end
                        M_WDATA: begin
                            regs[ptr[6:0]] = shift;
                            if (ptr == 8'h6B) begin
                                sleep_o = shift[6];
                            end
                            if (write_cnt_o == 0) begin
                                first_wr_reg_o  = ptr;
                                first_wr_data_o = shift;
                            end
                            write_cnt_o = write_cnt_o + 1;
                            ptr         = ptr + 8'd1;
                            sda_pull_o  = 1'b1;
                        end
                        M_READ: begin
                            ptr        = ptr + 8'd1;
                            sda_pull_o = 1'b0;    // master owns the ack slot
                            if (write_cnt_o == 0) begin
                                read_before_wake_o = 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end else if (phase == M_READ) begin
                    sda_pull_o = !tx[3'd7 - bit_cnt[2:0]];
                end
            end
            prev_scl = scl_i;
            prev_sda = sda_i;
        end
    end

endmodule

//--- test/tb_imu_reader.sv
module tb_imu_reader;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCL_LOW     = 8;
    localparam int SCL_HIGH    = 8;
    localparam int POLL        = 64;
    localparam int NUM_SAMPLES = 9;
    localparam int SAMPLE_WINDOW = 6 * (POLL + 40 * (SCL_LOW + SCL_HIGH));
    localparam int CYCLE_LIMIT   = SAMPLE_WINDOW * (NUM_SAMPLES + 1) + 2000;

    logic           clk;
    logic           gen_reset_n;
    logic           tb_reset_n;
    logic           reset_n;
    logic           nack_en;
    logic           scl_oe;
    logic           sda_oe;
    logic           sda_pull;
    logic           scl_line;
    logic           sda_line;
    logic           sample_valid;
    logic           error;
    imu_pkg::word_t data1;
    imu_pkg::word_t data2;
    imu_pkg::word_t data3;
    logic           sleep;
    logic           read_before_wake;
    logic [7:0]     first_wr_reg;
    logic [7:0]     first_wr_data;
    int             write_cnt;

    logic [31:0] lfsr_q;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          sample_cnt;
    int          cycle_cnt;
    int          last_cycle;
    logic        in_nack_test;

    assign reset_n  = gen_reset_n && tb_reset_n;
    assign scl_line = !scl_oe;                // pull-ups on both lines
    assign sda_line = !(sda_oe || sda_pull);

    tb_clock_gen i_clk_gen (
        .clk_o     (clk),
        .reset_n_o (gen_reset_n)
    );

    imu_reader_top #(
        .SCL_LOW_CYCLES  (SCL_LOW),
        .SCL_HIGH_CYCLES (SCL_HIGH),
        .POLL_CYCLES     (POLL)
    ) i_dut (
        .clk_i          (clk),
        .reset_n        (reset_n),
        .sda_i          (sda_line),
        .scl_oe_o       (scl_oe),
        .sda_oe_o       (sda_oe),
        .sample_valid_o (sample_valid),
        .error_o        (error),
        .data1_o        (data1),
        .data2_o        (data2),
        .data3_o        (data3)
    );

    i2c_sensor_model i_sensor (
        .clk_i              (clk),
        .reset_n            (reset_n),
        .scl_i              (scl_line),
        .sda_i              (sda_line),
        .nack_en_i          (nack_en),
        .sda_pull_o         (sda_pull),
        .sleep_o            (sleep),
        .read_before_wake_o (read_before_wake),
        .first_wr_reg_o     (first_wr_reg),
        .first_wr_data_o    (first_wr_data),
        .write_cnt_o        (write_cnt)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b      = {b[6:0], lfsr_q[0]};
        end
    endtask

    task automatic fill_regs();
        logic [7:0] b;
        for (int a = 0; a < 128; a++) begin
            next_byte(b);
            i_sensor.regs[a] = b;
        end
    endtask

    // high byte first, two values per word, lower value in the low half
    function automatic void expected_words(input logic [7:0] b [14],
                                           output imu_pkg::word_t d1,
                                           output imu_pkg::word_t d2,
                                           output imu_pkg::word_t d3);
        d1 = {b[2], b[3], b[0], b[1]};
        d2 = {b[8], b[9], b[4], b[5]};
        d3 = {b[12], b[13], b[10], b[11]};
    endfunction

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // compare each strobe against the sensor's current burst bytes
    always @(negedge clk) begin
        logic [7:0]     b [14];
        imu_pkg::word_t e1;
        imu_pkg::word_t e2;
        imu_pkg::word_t e3;
        if (reset_n && sample_valid) begin
            assert (!in_nack_test) else begin
                $display("sample strobe appeared although the sensor refused its address");
                errors++;
            end
            for (int i = 0; i < 14; i++) begin
                b[i] = i_sensor.regs[8'h3B + i];
            end
            expected_words(b, e1, e2, e3);
            assert (data1 == e1) else begin
                $display("mismatch data1_o expected %h actual %h", e1, data1);
                errors++;
            end
            assert (data2 == e2) else begin
                $display("mismatch data2_o expected %h actual %h", e2, data2);
                errors++;
            end
            assert (data3 == e3) else begin
                $display("mismatch data3_o expected %h actual %h", e3, data3);
                errors++;
            end
            assert (sample_cnt == 0 || cycle_cnt - last_cycle >= POLL) else begin
                $display("sample came only %0d cycles after the previous one",
                         cycle_cnt - last_cycle);
                errors++;
            end
            last_cycle = cycle_cnt;
            sample_cnt++;
        end
    end

    initial begin
        int err0;
        int waited;
        tb_reset_n   = 1'b1;
        nack_en      = 1'b0;
        in_nack_test = 1'b0;
        lfsr_q       = 32'h55439112;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        sample_cnt   = 0;
        cycle_cnt    = 0;
        last_cycle   = 0;
        fill_regs();

        err0 = errors;
        @(negedge clk);
        wait (gen_reset_n);
        @(negedge clk);
        assert (!sample_valid) else begin
            $display("mismatch sample_valid_o expected 0 actual %h", sample_valid);
            errors++;
        end
        assert (!error) else begin
            $display("mismatch error_o expected 0 actual %h", error);
            errors++;
        end
        assert (!scl_oe) else begin
            $display("mismatch scl_oe_o expected 0 actual %h", scl_oe);
            errors++;
        end
        assert (!sda_oe) else begin
            $display("mismatch sda_oe_o expected 0 actual %h", sda_oe);
            errors++;
        end
        report_test("reset values", err0);

        err0 = errors;
        wait (sample_cnt == 1);
        assert (write_cnt >= 1) else begin
            $display("no register write reached the sensor before the first sample");
            errors++;
        end
        assert (first_wr_reg == 8'h6B) else begin
            $display("mismatch first_wr_reg expected 6b actual %h", first_wr_reg);
            errors++;
        end
        assert (first_wr_data == 8'h00) else begin
            $display("mismatch first_wr_data expected 00 actual %h", first_wr_data);
            errors++;
        end
        assert (!read_before_wake) else begin
            $display("a read happened before the wake-up write");
            errors++;
        end
        assert (!sleep) else begin
            $display("sensor still asleep at the first sample");
            errors++;
        end
        report_test("wake-up write and first sample", err0);

        err0 = errors;
        for (int k = 1; k < NUM_SAMPLES; k++) begin
            fill_regs();
            wait (sample_cnt == k + 1);
        end
        report_test("eight consecutive samples", err0);

        err0 = errors;
        @(negedge clk);
        in_nack_test = 1'b1;
        nack_en      = 1'b1;
        tb_reset_n   = 1'b0;
        repeat (5) @(negedge clk);
        tb_reset_n = 1'b1;
        waited     = 0;
        while (!error && waited < SAMPLE_WINDOW) begin
            @(negedge clk);
            waited++;
        end
        assert (error) else begin
            $display("error_o never rose after the refused address");
            errors++;
        end
        while (waited < SAMPLE_WINDOW) begin
            @(negedge clk);
            waited++;
            assert (error) else begin
                $display("error_o dropped while the fault should hold");
                errors++;
            end
        end
        assert (!scl_oe && !sda_oe) else begin
            $display("bus enables still active after the fault");
            errors++;
        end
        report_test("refused address", err0);

        $display("tests run %0d, failed %0d, samples %0d, errors %0d",
                 tests_run, tests_failed, sample_cnt, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/imu_pkg.sv
rtl/i2c_scl_gen.sv
rtl/i2c_byte_engine.sv
rtl/imu_sequencer.sv
rtl/imu_sample_assembler.sv
rtl/imu_reader_top.sv
test/tb_clock_gen.sv
test/i2c_sensor_model.sv
test/tb_imu_reader.sv

//--- Bender.yml
package:
  name: imu_reader

sources:
  - rtl/imu_pkg.sv
  - rtl/i2c_scl_gen.sv
  - rtl/i2c_byte_engine.sv
  - rtl/imu_sequencer.sv
  - rtl/imu_sample_assembler.sv
  - rtl/imu_reader_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/i2c_sensor_model.sv
      - test/tb_imu_reader.sv
